// File: verilog/dfpDiv_cfg.svh
`ifndef DFPDIV_CFG_SVH
`define DFPDIV_CFG_SVH

// ------------------------------
// decimal float divider sizing
// ------------------------------

// significand length in bcd digits
`define DFP_DIGITS 7

// biased exponent field width, all ones marks inf/nan
`define DFP_EXP_BITS 8
`define DFP_BIAS 127

// extra quotient digits beyond the significand
// round digit plus one more below it
`define DFP_GUARD 2

`endif

// File: verilog/dfpPkg.sv
`include "dfpDiv_cfg.svh"

package dfpPkg;

	// ------------------------------
	// operand / result word
	// ------------------------------
	// value = sig * 10^(exp - bias - (digits-1))
	// exp all ones: sig zero is inf, otherwise nan
	typedef struct packed {
		logic sign;
		logic [`DFP_EXP_BITS-1:0] exp;
		logic [`DFP_DIGITS*4-1:0] sig;
	} dfpWord;

	// operand or result category
	typedef enum logic [1:0] {
		clsNormal,
		clsZero,
		clsInf,
		clsNan
	} dfpClass;

	// exception flags, same order as ieee 754
	typedef struct packed {
		logic invalid;
		logic divByZero;
		logic overflow;
		logic underflow;
		logic inexact;
	} dfpFlags;

	// intermediate result between pipeline stages
	// exp is signed and two bits wider so under/overflow is still visible
	typedef struct packed {
		logic sign;
		dfpClass cls;
		logic signed [`DFP_EXP_BITS+1:0] exp;
		logic [(`DFP_DIGITS+`DFP_GUARD)*4-1:0] quot;
		logic sticky;
		dfpFlags flags;
	} dfpQuot;

	typedef enum logic [2:0] {
		rmHalfEven,
		rmZero,
		// toward +inf
		rmUp,
		// toward -inf
		rmDown,
		rmHalfAway
	} roundMode;

endpackage

// File: verilog/bcdDivider.sv
`timescale 1ns/100ps
`include "dfpDiv_cfg.svh"

module bcdDivider (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  logic [`DFP_DIGITS*4-1:0] dividend,
	input  logic [`DFP_DIGITS*4-1:0] divisor,
	output logic [(`DFP_DIGITS+`DFP_GUARD)*4-1:0] quotient,
	output logic remNonZero,
	output logic done
);
	localparam int Digits = `DFP_DIGITS;
	localparam int QDigits = Digits + `DFP_GUARD;
	localparam int RemBits = (Digits + 1) * 4;
	localparam int CntW = $clog2(QDigits);

	logic busy;
	// partial remainder, one digit wider than the divisor
	logic [RemBits-1:0] rem;
	logic [Digits*4-1:0] dvsr;
	logic [RemBits-1:0] sub;
	logic [RemBits-1:0] diff;
	logic borrow;
	// running value of the digit being developed
	logic [3:0] digit;
	logic [CntW-1:0] digCnt;

	assign sub = {4'h0, dvsr};

	// ------------------------------
	// bcd subtract, doubles as compare
	// ------------------------------
	// final borrow set means rem < divisor
	always_comb begin
		logic [4:0] d;
		borrow = 1'b0;
		for (int i = 0; i <= Digits; i++) begin
			d = {1'b0, rem[i*4+:4]} - {1'b0, sub[i*4+:4]} - {4'b0, borrow};
			if (d[4]) begin
				// went negative, fold back into 0..9
				diff[i*4+:4] = d[3:0] + 4'd10;
				borrow = 1'b1;
			end else begin
				diff[i*4+:4] = d[3:0];
				borrow = 1'b0;
			end
		end
	end

	// control: busy until the last digit has been shifted in
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (ce) begin
			done <= 1'b0;
			if (ld) begin
				busy <= 1'b1;
			end else if (busy && borrow && digCnt == CntW'(QDigits - 1)) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// ------------------------------
	// datapath
	// ------------------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			if (ld) begin
				rem <= {4'h0, dividend};
				dvsr <= divisor;
				digit <= 4'd0;
				digCnt <= '0;
			end else if (busy) begin
				if (!borrow) begin
					// divisor still fits, take it out once more
					rem <= diff;
					digit <= digit + 4'd1;
				end else begin
					// digit finished, shift it in and move rem up a decade
					quotient <= {quotient[(QDigits-1)*4-1:0], digit};
					rem <= {rem[Digits*4-1:0], 4'h0};
					digit <= 4'd0;
					digCnt <= digCnt + CntW'(1);
					// last value seen becomes the sticky bit
					remNonZero <= rem != '0;
				end
			end
		end
	end

endmodule

// File: verilog/dfpDivide.sv
`timescale 1ns/100ps
`include "dfpDiv_cfg.svh"

module dfpDivide (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  dfpPkg::dfpWord a,
	input  dfpPkg::dfpWord b,
	input  dfpPkg::roundMode rm,
	output dfpPkg::dfpQuot q,
	output dfpPkg::roundMode rmOut,
	output logic valid
);
	import dfpPkg::*;

	localparam int Digits = `DFP_DIGITS;
	localparam int SigBits = Digits * 4;
	localparam int ExpW = `DFP_EXP_BITS + 2;
	localparam int QuotBits = (Digits + `DFP_GUARD) * 4;

	logic busy;
	// one-cycle strobe, second clock of an operation
	logic start;
	logic accept;

	// clock 1 operand registers
	logic [SigBits-1:0] aSig;
	logic [SigBits-1:0] bSig;
	logic signQ;
	logic [ExpW-1:0] expQ;
	dfpClass aCls;
	dfpClass bCls;

	int lzA;
	int lzB;
	int expCalc;

	dfpClass resCls;
	dfpFlags resFlags;
	logic special;

	logic [QuotBits-1:0] divQuot;
	logic divRem;
	logic divDone;

	function automatic dfpClass classify(input dfpWord w);
		if (&w.exp)
			return (w.sig == '0) ? clsInf : clsNan;
		return (w.sig == '0) ? clsZero : clsNormal;
	endfunction

	// leading zero bcd digits, all digits for a zero significand
	function automatic int leadZeros(input logic [SigBits-1:0] s);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		for (int i = Digits - 1; i >= 0; i--) begin
			if (s[i*4+:4] != 4'd0)
				seen = 1'b1;
			else if (!seen)
				n = n + 1;
		end
		return n;
	endfunction

	// ------------------------------
	// clock 1: classify and align
	// ------------------------------
	assign accept = ld && !busy;

	always_comb begin
		lzA = leadZeros(a.sig);
		lzB = leadZeros(b.sig);
		// aligning shifts move the decimal point, so correct for them here
		expCalc = int'(a.exp) - int'(b.exp) + `DFP_BIAS - lzA + lzB;
	end

	always_ff @(posedge clk) begin
		if (ce && accept) begin
			aSig <= a.sig << (4 * lzA);
			bSig <= b.sig << (4 * lzB);
			signQ <= a.sign ^ b.sign;
			expQ <= expCalc[ExpW-1:0];
			aCls <= classify(a);
			bCls <= classify(b);
			rmOut <= rm;
		end
	end

	// special results in priority order
	always_comb begin
		resCls = clsNormal;
		resFlags = '0;
		if (aCls == clsNan || bCls == clsNan ||
			(aCls == clsZero && bCls == clsZero) ||
			(aCls == clsInf && bCls == clsInf)) begin
			resCls = clsNan;
			resFlags.invalid = 1'b1;
		end else if (bCls == clsZero && aCls == clsNormal) begin
			resCls = clsInf;
			resFlags.divByZero = 1'b1;
		end else if (aCls == clsInf) begin
			resCls = clsInf;
		end else if (aCls == clsZero || bCls == clsInf) begin
			resCls = clsZero;
		end
	end

	assign special = resCls != clsNormal;

	// ------------------------------
	// clock 2 on: divide or bypass
	// ------------------------------
	bcdDivider divider (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(start && !special),
		.dividend(aSig),
		.divisor(bSig),
		.quotient(divQuot),
		.remNonZero(divRem),
		.done(divDone)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			start <= 1'b0;
			valid <= 1'b0;
		end else if (ce) begin
			start <= 1'b0;
			valid <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				start <= 1'b1;
			end else if ((start && special) || divDone) begin
				busy <= 1'b0;
				valid <= 1'b1;
			end
		end
	end

	// result word for the normalize stage
	always_ff @(posedge clk) begin
		if (ce && ((start && special) || divDone)) begin
			q.sign <= signQ;
			q.cls <= resCls;
			q.exp <= expQ;
			q.quot <= special ? '0 : divQuot;
			q.sticky <= !special && divRem;
			q.flags <= resFlags;
		end
	end

endmodule

// File: verilog/dfpNormalize.sv
`timescale 1ns/100ps
`include "dfpDiv_cfg.svh"

module dfpNormalize (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic validIn,
	input  dfpPkg::dfpQuot qIn,
	input  dfpPkg::roundMode rmIn,
	output dfpPkg::dfpQuot qOut,
	output dfpPkg::roundMode rmOut,
	output logic validOut
);
	import dfpPkg::*;

	localparam int QuotBits = (`DFP_DIGITS + `DFP_GUARD) * 4;
	localparam int ExpW = `DFP_EXP_BITS + 2;

	logic [3:0] leadDigit;
	logic needShift;

	// aligned operands keep the quotient in [0.1, 10)
	// so at most one leading zero digit shows up
	assign leadDigit = qIn.quot[QuotBits-1-:4];
	assign needShift = qIn.cls == clsNormal && leadDigit == 4'd0;

	always_ff @(posedge clk) begin
		if (rst)
			validOut <= 1'b0;
		else if (ce)
			validOut <= validIn;
	end

	// ------------------------------
	// single digit shift
	// ------------------------------
	always_ff @(posedge clk) begin
		if (ce && validIn) begin
			qOut <= qIn;
			rmOut <= rmIn;
			if (needShift) begin
				// zero fills the bottom, sticky is left alone
				qOut.quot <= {qIn.quot[QuotBits-5:0], 4'h0};
				qOut.exp <= qIn.exp - ExpW'(1);
			end
		end
	end

endmodule

// File: verilog/dfpRound.sv
`timescale 1ns/100ps
`include "dfpDiv_cfg.svh"

module dfpRound (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic validIn,
	input  dfpPkg::dfpQuot qIn,
	input  dfpPkg::roundMode rm,
	output dfpPkg::dfpWord o,
	output dfpPkg::dfpFlags flags,
	output logic done
);
	import dfpPkg::*;

	localparam int Digits = `DFP_DIGITS;
	localparam int Guard = `DFP_GUARD;
	localparam int SigBits = Digits * 4;
	localparam int QuotBits = (Digits + Guard) * 4;
	localparam int ExpBits = `DFP_EXP_BITS;
	localparam int ExpW = ExpBits + 2;
	// largest finite biased exponent
	localparam int MaxExp = (1 << ExpBits) - 2;
	localparam logic [SigBits-1:0] SigOne = {4'h1, {(SigBits - 4){1'b0}}};

	logic [SigBits-1:0] kept;
	logic [3:0] rndDigit;
	logic restNz;
	logic inexact;
	logic incr;
	logic carry;
	logic [SigBits-1:0] sigInc;
	logic [SigBits-1:0] sigFinal;
	logic signed [ExpW-1:0] expFinal;
	dfpWord wordNext;
	dfpFlags flagsNext;

	// ------------------------------
	// increment decision
	// ------------------------------
	always_comb begin
		kept = qIn.quot[QuotBits-1-:SigBits];
		rndDigit = qIn.quot[(Guard-1)*4+:4];
		restNz = (qIn.quot[(Guard-1)*4-1:0] != '0) || qIn.sticky;
		inexact = (rndDigit != 4'd0) || restNz;
		case (rm)
			// ties go to the even last digit
			rmHalfEven: incr = rndDigit > 4'd5 || (rndDigit == 4'd5 && (restNz || kept[0]));
			rmZero: incr = 1'b0;
			rmUp: incr = inexact && !qIn.sign;
			rmDown: incr = inexact && qIn.sign;
			rmHalfAway: incr = rndDigit >= 4'd5;
			default: incr = 1'b0;
		endcase
		// bcd +1 ripple, nines roll over to zero
		carry = incr;
		for (int i = 0; i < Digits; i++) begin
			if (carry && kept[i*4+:4] == 4'd9) begin
				sigInc[i*4+:4] = 4'd0;
			end else if (carry) begin
				sigInc[i*4+:4] = kept[i*4+:4] + 4'd1;
				carry = 1'b0;
			end else begin
				sigInc[i*4+:4] = kept[i*4+:4];
			end
		end
		// all nines rounded up: 1000000 one decade higher
		sigFinal = carry ? SigOne : sigInc;
		expFinal = qIn.exp + ExpW'(carry);
	end

	// ------------------------------
	// range check and encode
	// ------------------------------
	always_comb begin
		flagsNext = qIn.flags;
		wordNext.sign = qIn.sign;
		wordNext.exp = expFinal[ExpBits-1:0];
		wordNext.sig = sigFinal;
		case (qIn.cls)
			clsNan: begin
				// canonical quiet nan
				wordNext.sign = 1'b0;
				wordNext.exp = '1;
				wordNext.sig = SigOne;
			end
			clsInf: begin
				wordNext.exp = '1;
				wordNext.sig = '0;
			end
			clsZero: begin
				wordNext.exp = '0;
				wordNext.sig = '0;
			end
			default: begin
				flagsNext.inexact = inexact;
				if (expFinal > MaxExp) begin
					wordNext.exp = '1;
					wordNext.sig = '0;
					flagsNext.overflow = 1'b1;
					flagsNext.inexact = 1'b1;
				end else if (expFinal < 0) begin
					// no subnormals, flush to a signed zero
					wordNext.exp = '0;
					wordNext.sig = '0;
					flagsNext.underflow = 1'b1;
					flagsNext.inexact = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o <= '0;
			flags <= '0;
			done <= 1'b0;
		end else if (ce) begin
			done <= validIn;
			if (validIn) begin
				o <= wordNext;
				flags <= flagsNext;
			end
		end
	end

endmodule

// File: verilog/dfpDivideTop.sv
`timescale 1ns/100ps

module dfpDivideTop (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  dfpPkg::dfpWord a,
	input  dfpPkg::dfpWord b,
	input  dfpPkg::roundMode rm,
	output dfpPkg::dfpWord o,
	output dfpPkg::dfpFlags flags,
	output logic done
);
	import dfpPkg::*;

	// divide stage to normalize
	dfpQuot divQ;
	roundMode divRm;
	logic divValid;

	// normalize to round
	dfpQuot normQ;
	roundMode normRm;
	logic normValid;

	// ------------------------------
	// divide, variable latency
	// ------------------------------
	dfpDivide divStage (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.a(a),
		.b(b),
		.rm(rm),
		.q(divQ),
		.rmOut(divRm),
		.valid(divValid)
	);

	// one clock each from here to done
	dfpNormalize normStage (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.validIn(divValid),
		.qIn(divQ),
		.rmIn(divRm),
		.qOut(normQ),
		.rmOut(normRm),
		.validOut(normValid)
	);

	dfpRound roundStage (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.validIn(normValid),
		.qIn(normQ),
		.rm(normRm),
		.o(o),
		.flags(flags),
		.done(done)
	);

endmodule

// File: test/dfpVectors.svh
`ifndef DFP_VECTORS_SVH
`define DFP_VECTORS_SVH

// columns: operand a, operand b, rounding mode, expected o, expected flags
// words are sign_exp_sig in hex, sig as 7 bcd digits, exp biased by 0x7f
// flags are {invalid, divByZero, overflow, underflow, inexact}
task automatic loadVectors();
	// ------------------------------
	// exact quotients
	addVector(37'h0_7f_6000000, 37'h0_7f_3000000, rmHalfEven, 37'h0_7f_2000000, 5'b00000);
	addVector(37'h0_7f_1000000, 37'h0_7f_8000000, rmHalfEven, 37'h0_7e_1250000, 5'b00000);
	// unnormalized operands, 120e-6 / 4e-6
	addVector(37'h0_7f_0000120, 37'h0_7f_0000004, rmHalfEven, 37'h0_80_3000000, 5'b00000);
	addVector(37'h0_82_7500000, 37'h0_7d_2500000, rmZero, 37'h0_84_3000000, 5'b00000);
	addVector(37'h1_7f_9000000, 37'h0_7f_3000000, rmHalfEven, 37'h1_7f_3000000, 5'b00000);
	// ------------------------------
	// 2/3 under every mode
	addVector(37'h0_7f_2000000, 37'h0_7f_3000000, rmHalfEven, 37'h0_7e_6666667, 5'b00001);
	addVector(37'h0_7f_2000000, 37'h0_7f_3000000, rmZero, 37'h0_7e_6666666, 5'b00001);
	addVector(37'h0_7f_2000000, 37'h0_7f_3000000, rmUp, 37'h0_7e_6666667, 5'b00001);
	addVector(37'h0_7f_2000000, 37'h0_7f_3000000, rmDown, 37'h0_7e_6666666, 5'b00001);
	addVector(37'h0_7f_2000000, 37'h0_7f_3000000, rmHalfAway, 37'h0_7e_6666667, 5'b00001);
	// -2/3, directed modes flip on the sign
	addVector(37'h1_7f_2000000, 37'h0_7f_3000000, rmHalfEven, 37'h1_7e_6666667, 5'b00001);
	addVector(37'h1_7f_2000000, 37'h0_7f_3000000, rmZero, 37'h1_7e_6666666, 5'b00001);
	addVector(37'h1_7f_2000000, 37'h0_7f_3000000, rmUp, 37'h1_7e_6666666, 5'b00001);
	addVector(37'h1_7f_2000000, 37'h0_7f_3000000, rmDown, 37'h1_7e_6666667, 5'b00001);
	addVector(37'h1_7f_2000000, 37'h0_7f_3000000, rmHalfAway, 37'h1_7e_6666667, 5'b00001);
	// 1/7, round digit 4
	addVector(37'h0_7f_1000000, 37'h0_7f_7000000, rmHalfEven, 37'h0_7e_1428571, 5'b00001);
	addVector(37'h0_7f_1000000, 37'h0_7f_7000000, rmZero, 37'h0_7e_1428571, 5'b00001);
	addVector(37'h0_7f_1000000, 37'h0_7f_7000000, rmUp, 37'h0_7e_1428572, 5'b00001);
	addVector(37'h0_7f_1000000, 37'h0_7f_7000000, rmDown, 37'h0_7e_1428571, 5'b00001);
	addVector(37'h0_7f_1000000, 37'h0_7f_7000000, rmHalfAway, 37'h0_7e_1428571, 5'b00001);
	// exact ties, 1000000.5 and 1000001.5
	addVector(37'h0_85_2000001, 37'h0_7f_2000000, rmHalfEven, 37'h0_85_1000000, 5'b00001);
	addVector(37'h0_85_2000001, 37'h0_7f_2000000, rmHalfAway, 37'h0_85_1000001, 5'b00001);
	addVector(37'h0_85_2000003, 37'h0_7f_2000000, rmHalfEven, 37'h0_85_1000002, 5'b00001);
	// 1.9999998 ripples through the nines
	addVector(37'h0_7f_9999999, 37'h0_7f_5000000, rmHalfEven, 37'h0_7f_2000000, 5'b00001);
	addVector(37'h0_7f_9999999, 37'h0_7f_5000000, rmZero, 37'h0_7f_1999999, 5'b00001);
	// 9.999999 / 1.000001 = 9.99998900001...
	addVector(37'h0_7f_9999999, 37'h0_7f_1000001, rmHalfEven, 37'h0_7f_9999989, 5'b00001);
	addVector(37'h0_7f_9999999, 37'h0_7f_1000001, rmUp, 37'h0_7f_9999990, 5'b00001);
	// ------------------------------
	// special operands
	addVector(37'h0_7f_5000000, 37'h0_00_0000000, rmHalfEven, 37'h0_ff_0000000, 5'b01000);
	addVector(37'h1_7f_5000000, 37'h0_00_0000000, rmHalfEven, 37'h1_ff_0000000, 5'b01000);
	addVector(37'h0_00_0000000, 37'h0_00_0000000, rmHalfEven, 37'h0_ff_1000000, 5'b10000);
	addVector(37'h0_ff_0000000, 37'h1_ff_0000000, rmHalfEven, 37'h0_ff_1000000, 5'b10000);
	addVector(37'h1_ff_1234567, 37'h0_7f_2000000, rmHalfEven, 37'h0_ff_1000000, 5'b10000);
	addVector(37'h0_7f_3000000, 37'h0_ff_0000001, rmHalfEven, 37'h0_ff_1000000, 5'b10000);
	addVector(37'h1_7f_7000000, 37'h0_ff_0000000, rmHalfEven, 37'h1_00_0000000, 5'b00000);
	addVector(37'h0_ff_0000000, 37'h1_7f_2000000, rmHalfEven, 37'h1_ff_0000000, 5'b00000);
	addVector(37'h0_00_0000000, 37'h1_7f_5000000, rmHalfEven, 37'h1_00_0000000, 5'b00000);
	addVector(37'h0_ff_0000000, 37'h0_00_0000000, rmHalfEven, 37'h0_ff_0000000, 5'b00000);
	// ------------------------------
	// exponent range, 254 and 0 are the last finite values
	addVector(37'h0_fe_9000000, 37'h0_00_1000000, rmHalfEven, 37'h0_ff_0000000, 5'b00101);
	addVector(37'h1_fe_9000000, 37'h0_00_1000000, rmHalfEven, 37'h1_ff_0000000, 5'b00101);
	addVector(37'h1_00_1000000, 37'h0_fe_9000000, rmHalfEven, 37'h1_00_0000000, 5'b00011);
	addVector(37'h0_fe_6000000, 37'h0_7f_3000000, rmHalfEven, 37'h0_fe_2000000, 5'b00000);
	addVector(37'h0_fe_6000000, 37'h0_7e_3000000, rmHalfEven, 37'h0_ff_0000000, 5'b00101);
	addVector(37'h0_00_6000000, 37'h0_7f_3000000, rmHalfEven, 37'h0_00_2000000, 5'b00000);
	addVector(37'h0_00_1000000, 37'h0_7f_3000000, rmHalfEven, 37'h0_00_0000000, 5'b00011);
endtask

`endif

// File: test/dfpDivideTb.sv
`timescale 1ns/100ps
`include "dfpDiv_cfg.svh"

module dfpDivideTb;
	import dfpPkg::*;

	// table runs once with ce high and once with random stalls
	localparam int Passes = 2;

	logic clk = 1'b0;
	logic rst;
	logic ce;
	logic ld;
	dfpWord a;
	dfpWord b;
	roundMode rm;
	dfpWord o;
	dfpFlags flags;
	logic done;

	logic stallMode;

	// stimulus table filled by loadVectors
	dfpWord vecA[$];
	dfpWord vecB[$];
	roundMode vecRm[$];
	dfpWord vecO[$];
	dfpFlags vecFlags[$];

	dfpDivideTop UUT (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.a(a),
		.b(b),
		.rm(rm),
		.o(o),
		.flags(flags),
		.done(done)
	);

	// 100 ns period
	always #50 clk = ~clk;

	task automatic addVector(input dfpWord va, input dfpWord vb, input roundMode vrm,
		input dfpWord vo, input dfpFlags vf);
		vecA.push_back(va);
		vecB.push_back(vb);
		vecRm.push_back(vrm);
		vecO.push_back(vo);
		vecFlags.push_back(vf);
	endtask

	`include "dfpVectors.svh"

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// ------------------------------
	// one table entry
	// ------------------------------
	task automatic runVector(input int idx);
		a <= vecA[idx];
		b <= vecB[idx];
		rm <= vecRm[idx];
		ld <= 1'b1;
		// ld stays up until an edge with ce high takes it
		@(posedge clk);
		while (!ce)
			@(posedge clk);
		ld <= 1'b0;
		// done from the previous entry was cleared on the accepting edge
		@(posedge clk);
		while (!done)
			@(posedge clk);
		checkValue($sformatf("o[%0d]", idx), 64'(o), 64'(vecO[idx]));
		checkValue($sformatf("flags[%0d]", idx), 64'(flags), 64'(vecFlags[idx]));
	endtask

	task automatic runTable();
		for (int i = 0; i < vecA.size(); i++)
			runVector(i);
	endtask

	// ce low on about 30% of clocks once stalls are on
	initial begin : ceDriver
		void'($urandom(7229));
		ce <= 1'b1;
		forever begin
			@(posedge clk);
			if (stallMode)
				ce <= ($urandom % 100) >= 30;
			else
				ce <= 1'b1;
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : mainSeq
		rst <= 1'b1;
		ld <= 1'b0;
		a <= '0;
		b <= '0;
		rm <= rmHalfEven;
		stallMode <= 1'b0;
		loadVectors();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// nothing loaded yet so outputs hold their reset values
		checkValue("done", 64'(done), 64'd0);
		checkValue("o", 64'(o), 64'd0);
		checkValue("flags", 64'(flags), 64'd0);
		runTable();
		stallMode <= 1'b1;
		runTable();
		$display("RESULT: PASS");
		$finish;
	end

	// worst case is every quotient digit at 10 clocks per entry and x4 for stalls
	initial begin : watchdog
		longint limitNs;
		#1;
		limitNs = longint'(Passes) * longint'(vecA.size());
		limitNs = limitNs * (`DFP_DIGITS + 2) * 10 * 4 * 100 + 1000;
		#(limitNs);
		$display("RESULT: FAIL");
		$fatal(1, "timeout, the DUT gave no done within %0d ns", limitNs);
	end

endmodule

// File: files.f
+incdir+verilog
+incdir+test
verilog/dfpPkg.sv
verilog/bcdDivider.sv
verilog/dfpDivide.sv
verilog/dfpNormalize.sv
verilog/dfpRound.sv
verilog/dfpDivideTop.sv
test/dfpDivideTb.sv

// File: Makefile
TOP = dfpDivideTb

.PHONY: all lint sim clean

all: sim

# full warning report on the whole project
lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f

# build and run, a $$fatal in the testbench gives a non-zero exit status
sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
